/* sa_array_pkg.sv */
package sa_array_pkg;

    // default array geometry
    localparam int N_ROWS_DEF = 4;
    localparam int N_COLS_DEF = 4;

    // largest filter size the array supports
    localparam int MAX_FILTER = 3;

    // per-row field widths of a signal ROM word
    localparam int F_SEL_W      = 2;
    localparam int NUM_COLS_W   = 2;
    localparam int SEL_MUX_TR_W = 2;

    // bits one row takes in a ROM word including the adder enable bit
    localparam int ROW_BITS = F_SEL_W + NUM_COLS_W + SEL_MUX_TR_W + 1;

    typedef logic [F_SEL_W-1:0]      f_sel_t;
    typedef logic [NUM_COLS_W-1:0]   num_cols_t;
    typedef logic [SEL_MUX_TR_W-1:0] sel_mux_tr_t;

    localparam int ROM_ADDR_W = 10;

endpackage

/* sa_ctrl_pkg.sv */
package sa_ctrl_pkg;

    // phases of one weight round
    typedef enum logic [2:0] {
        idle  = 3'd0,
        load  = 3'd1,
        ready = 3'd2,
        start = 3'd3,
        drain = 3'd4
    } phase_t;

    // ready phase length in cycles
    localparam int READY_LEN = 3;

    // drain takes 2*(filter-1) + DRAIN_BASE + 1 cycles
    localparam int DRAIN_BASE = 6;

    localparam int ROUND_W     = 3;
    localparam int FEAT_ADDR_W = 5;
    localparam int PHASE_CNT_W = 4;

endpackage

/* sa_rom_field_reg.sv */
`timescale 1ns/1ps

module sa_rom_field_reg #(
    parameter type field_t = logic,
    parameter int  N_ROWS  = sa_array_pkg::N_ROWS_DEF,
    parameter int  STAGES  = 1
) (
    input  logic   clk_i,
    input  logic   sel_mux_tr_rst,
    input  logic   clr_i,
    input  logic   ld_i,
    input  field_t d_i [N_ROWS],
    output field_t q_o [N_ROWS]
);

    // rank 0 takes the new word and the last rank drives the outputs
    field_t stage_q [STAGES][N_ROWS];

    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst) begin
            stage_q <= '{default: '0};
        end else if (clr_i) begin
            stage_q <= '{default: '0};
        end else if (ld_i) begin
            stage_q[0] <= d_i;
            for (int s = 1; s < STAGES; s++) begin
                stage_q[s] <= stage_q[s-1];
            end
        end
    end

    assign q_o = stage_q[STAGES-1];

endmodule

/* sa_signal_bank.sv */
`timescale 1ns/1ps

module sa_signal_bank #(
    parameter int N_ROWS = sa_array_pkg::N_ROWS_DEF
) (
    input  logic                                   clk_i,
    input  logic                                   sel_mux_tr_rst,
    input  logic                                   bank_clr_i,
    input  logic                                   bank_ld_i,
    input  logic [N_ROWS*sa_array_pkg::ROW_BITS-1:0] rom_word_i,
    output sa_array_pkg::f_sel_t                   f_sel_o      [N_ROWS],
    output sa_array_pkg::num_cols_t                num_cols_o   [N_ROWS],
    output sa_array_pkg::sel_mux_tr_t              sel_mux_tr_o [N_ROWS],
    output logic                                   en_adder_o   [N_ROWS]
);
    import sa_array_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // rom word layout from the low end is f_sel, num_cols, sel_mux_tr, en
    //////////////////////////////////////////////////////////////////////

    localparam int NC_BASE = N_ROWS * F_SEL_W;
    localparam int SM_BASE = NC_BASE + N_ROWS * NUM_COLS_W;
    localparam int EA_BASE = SM_BASE + N_ROWS * SEL_MUX_TR_W;

    f_sel_t      f_sel_d      [N_ROWS];
    num_cols_t   num_cols_d   [N_ROWS];
    sel_mux_tr_t sel_mux_tr_d [N_ROWS];
    logic        en_adder_d   [N_ROWS];

    for (genvar r = 0; r < N_ROWS; r++) begin : g_slice
        assign f_sel_d[r]      = rom_word_i[r*F_SEL_W +: F_SEL_W];
        assign num_cols_d[r]   = rom_word_i[NC_BASE + r*NUM_COLS_W +: NUM_COLS_W];
        assign sel_mux_tr_d[r] = rom_word_i[SM_BASE + r*SEL_MUX_TR_W +: SEL_MUX_TR_W];
        assign en_adder_d[r]   = rom_word_i[EA_BASE + r];
    end

    sa_rom_field_reg #(.field_t(f_sel_t), .N_ROWS(N_ROWS), .STAGES(1)) u_f_sel_reg (
        .clk_i, .sel_mux_tr_rst, .clr_i(bank_clr_i), .ld_i(bank_ld_i),
        .d_i(f_sel_d), .q_o(f_sel_o)
    );

    sa_rom_field_reg #(.field_t(num_cols_t), .N_ROWS(N_ROWS), .STAGES(1)) u_num_cols_reg (
        .clk_i, .sel_mux_tr_rst, .clr_i(bank_clr_i), .ld_i(bank_ld_i),
        .d_i(num_cols_d), .q_o(num_cols_o)
    );

    // transfer select lags one word behind the others
    sa_rom_field_reg #(.field_t(sel_mux_tr_t), .N_ROWS(N_ROWS), .STAGES(2)) u_sel_mux_reg (
        .clk_i, .sel_mux_tr_rst, .clr_i(bank_clr_i), .ld_i(bank_ld_i),
        .d_i(sel_mux_tr_d), .q_o(sel_mux_tr_o)
    );

    sa_rom_field_reg #(.field_t(logic), .N_ROWS(N_ROWS), .STAGES(1)) u_en_adder_reg (
        .clk_i, .sel_mux_tr_rst, .clr_i(bank_clr_i), .ld_i(bank_ld_i),
        .d_i(en_adder_d), .q_o(en_adder_o)
    );

endmodule

/* sa_phase_fsm.sv */
`timescale 1ns/1ps

module sa_phase_fsm (
    input  logic clk_i,
    input  logic sel_mux_tr_rst,
    input  logic end_feature_i,
    input  logic load_done_i,
    input  logic ready_done_i,
    input  logic drain_done_i,
    input  logic last_round_i,
    output logic rst_o,
    output logic load_o,
    output logic ready_o,
    output logic start_op_o,
    output logic rd_weight_ld_o,
    output logic rd_weight_rst_o,
    output logic rd_feature_ld_o,
    output logic rd_rom_signals_ld_o,
    output logic load_cnt_clr_o,
    output logic load_cnt_en_o,
    output logic ready_cnt_clr_o,
    output logic ready_cnt_en_o,
    output logic drain_cnt_clr_o,
    output logic drain_cnt_en_o,
    output logic feat_clr_o,
    output logic feat_en_o,
    output logic round_clr_o,
    output logic bank_clr_o,
    output logic bank_ld_o
);
    import sa_ctrl_pkg::*;

    phase_t state_q;
    phase_t state_d;

    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst) begin
            state_q <= idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            idle:    if (!last_round_i) state_d = load;
            load:    if (load_done_i) state_d = ready;
            ready:   if (ready_done_i) state_d = start;
            start:   if (end_feature_i) state_d = drain;
            drain:   if (drain_done_i) state_d = last_round_i ? idle : load;
            default: state_d = idle;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // moore strobes and counter controls
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        {rst_o, load_o, ready_o, start_op_o} = '0;
        {rd_weight_ld_o, rd_weight_rst_o, rd_feature_ld_o, rd_rom_signals_ld_o} = '0;
        {load_cnt_clr_o, load_cnt_en_o, ready_cnt_clr_o, ready_cnt_en_o} = '0;
        {drain_cnt_clr_o, drain_cnt_en_o, feat_clr_o, feat_en_o} = '0;
        {round_clr_o, bank_clr_o, bank_ld_o} = '0;
        case (state_q)
            load: begin
                load_o              = 1'b1;
                rd_weight_ld_o      = 1'b1;
                rd_rom_signals_ld_o = 1'b1;
                load_cnt_en_o       = 1'b1;
                bank_ld_o           = 1'b1;
                ready_cnt_clr_o     = 1'b1;
                drain_cnt_clr_o     = 1'b1;
                feat_clr_o          = 1'b1;
            end
            ready: begin
                ready_o         = 1'b1;
                rd_feature_ld_o = 1'b1;
                ready_cnt_en_o  = 1'b1;
                load_cnt_clr_o  = 1'b1;
                feat_en_o       = 1'b1;
            end
            start: begin
                start_op_o      = 1'b1;
                rd_feature_ld_o = 1'b1;
                feat_en_o       = 1'b1;
                ready_cnt_clr_o = 1'b1;
                drain_cnt_clr_o = 1'b1;
            end
            drain: begin
                // array still busy while partial sums drain out
                start_op_o     = 1'b1;
                drain_cnt_en_o = 1'b1;
                feat_clr_o     = 1'b1;
            end
            default: begin
                rst_o           = 1'b1;
                rd_weight_rst_o = 1'b1;
                load_cnt_clr_o  = 1'b1;
                ready_cnt_clr_o = 1'b1;
                drain_cnt_clr_o = 1'b1;
                feat_clr_o      = 1'b1;
                round_clr_o     = 1'b1;
                bank_clr_o      = 1'b1;
            end
        endcase
    end

endmodule

/* sa_phase_counters.sv */
`timescale 1ns/1ps

module sa_phase_counters #(
    parameter int N_COLS = sa_array_pkg::N_COLS_DEF
) (
    input  logic                               clk_i,
    input  logic                               sel_mux_tr_rst,
    input  sa_array_pkg::num_cols_t            filter_size_i,
    input  logic                               load_cnt_clr_i,
    input  logic                               load_cnt_en_i,
    input  logic                               ready_cnt_clr_i,
    input  logic                               ready_cnt_en_i,
    input  logic                               drain_cnt_clr_i,
    input  logic                               drain_cnt_en_i,
    input  logic                               feat_clr_i,
    input  logic                               feat_en_i,
    output logic                               load_done_o,
    output logic                               ready_done_o,
    output logic                               drain_done_o,
    output logic [sa_ctrl_pkg::PHASE_CNT_W-1:0] load_count_o,
    output logic [sa_ctrl_pkg::FEAT_ADDR_W-1:0] feat_addr_o
);
    import sa_ctrl_pkg::*;

    logic [PHASE_CNT_W-1:0] load_cnt_q;
    logic [PHASE_CNT_W-1:0] ready_cnt_q;
    logic [PHASE_CNT_W-1:0] drain_cnt_q;
    logic [PHASE_CNT_W-1:0] drain_last;
    logic [FEAT_ADDR_W-1:0] feat_cnt_q;

    // clear wins over count in every counter
    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst) begin
            load_cnt_q  <= '0;
            ready_cnt_q <= '0;
            drain_cnt_q <= '0;
            feat_cnt_q  <= '0;
        end else begin
            if (load_cnt_clr_i) load_cnt_q <= '0;
            else if (load_cnt_en_i) load_cnt_q <= load_cnt_q + 1'b1;
            if (ready_cnt_clr_i) ready_cnt_q <= '0;
            else if (ready_cnt_en_i) ready_cnt_q <= ready_cnt_q + 1'b1;
            if (drain_cnt_clr_i) drain_cnt_q <= '0;
            else if (drain_cnt_en_i) drain_cnt_q <= drain_cnt_q + 1'b1;
            if (feat_clr_i) feat_cnt_q <= '0;
            else if (feat_en_i) feat_cnt_q <= feat_cnt_q + 1'b1;
        end
    end

    // last drain count is 2*(filter-1) + DRAIN_BASE
    assign drain_last = PHASE_CNT_W'({filter_size_i, 1'b0}) + PHASE_CNT_W'(DRAIN_BASE - 2);

    // flags only fire while their phase is counting
    assign load_done_o  = load_cnt_en_i && (load_cnt_q == PHASE_CNT_W'(N_COLS - 1));
    assign ready_done_o = ready_cnt_en_i && (ready_cnt_q == PHASE_CNT_W'(READY_LEN - 1));
    assign drain_done_o = drain_cnt_en_i && (drain_cnt_q == drain_last);

    assign load_count_o = load_cnt_q;
    assign feat_addr_o  = feat_cnt_q;

endmodule

/* sa_weight_round.sv */
`timescale 1ns/1ps

module sa_weight_round #(
    parameter int N_COLS = sa_array_pkg::N_COLS_DEF
) (
    input  logic                                clk_i,
    input  logic                                sel_mux_tr_rst,
    input  logic                                round_clr_i,
    input  logic                                load_done_i,
    input  logic [sa_ctrl_pkg::PHASE_CNT_W-1:0] load_count_i,
    input  logic [sa_ctrl_pkg::ROUND_W-1:0]     max_round_weight_i,
    output logic                                last_round_o,
    output logic [sa_array_pkg::ROM_ADDR_W-1:0] rom_addr_o
);
    import sa_array_pkg::*;
    import sa_ctrl_pkg::*;

    logic [ROUND_W-1:0] round_q;

    // one round per completed load phase
    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst) begin
            round_q <= '0;
        end else if (round_clr_i) begin
            round_q <= '0;
        end else if (load_done_i) begin
            round_q <= round_q + 1'b1;
        end
    end

    assign last_round_o = (round_q == max_round_weight_i);

    // each round owns N_COLS consecutive ROM words
    assign rom_addr_o = ROM_ADDR_W'(round_q) * ROM_ADDR_W'(N_COLS) + ROM_ADDR_W'(load_count_i);

endmodule

/* sa_ctrl_top.sv */
`timescale 1ns/1ps

module sa_ctrl_top #(
    parameter int N_ROWS = sa_array_pkg::N_ROWS_DEF,
    parameter int N_COLS = sa_array_pkg::N_COLS_DEF
) (
    input  logic                                     clk_i,
    input  logic                                     sel_mux_tr_rst,
    input  logic [N_ROWS*sa_array_pkg::ROW_BITS-1:0] rom_signals_data_i,
    input  sa_array_pkg::num_cols_t                  filter_size_i,
    input  logic                                     end_feature_i,
    input  logic [sa_ctrl_pkg::ROUND_W-1:0]          max_round_weight_i,
    output logic                                     rst_o,
    output logic                                     load_o,
    output logic                                     ready_o,
    output logic                                     start_op_o,
    output logic                                     rd_weight_ld_o,
    output logic                                     rd_weight_rst_o,
    output logic                                     rd_feature_ld_o,
    output logic                                     rd_rom_signals_ld_o,
    output logic [sa_ctrl_pkg::FEAT_ADDR_W-1:0]      in_feature_addr_o,
    output logic [sa_array_pkg::ROM_ADDR_W-1:0]      addrs_rom_signal_o,
    output sa_array_pkg::f_sel_t                     f_sel_o             [N_ROWS],
    output sa_array_pkg::num_cols_t                  number_of_columns_o [N_ROWS],
    output sa_array_pkg::sel_mux_tr_t                sel_mux_tr_o        [N_ROWS],
    output logic                                     en_adder_node_o     [N_ROWS]
);
    import sa_ctrl_pkg::*;

    logic load_cnt_clr, load_cnt_en, ready_cnt_clr, ready_cnt_en;
    logic drain_cnt_clr, drain_cnt_en, feat_clr, feat_en;
    logic round_clr, bank_clr, bank_ld;
    logic load_done, ready_done, drain_done, last_round;
    logic [PHASE_CNT_W-1:0] load_count;

    sa_phase_fsm u_fsm (
        .clk_i, .sel_mux_tr_rst, .end_feature_i,
        .load_done_i(load_done), .ready_done_i(ready_done),
        .drain_done_i(drain_done), .last_round_i(last_round),
        .rst_o, .load_o, .ready_o, .start_op_o,
        .rd_weight_ld_o, .rd_weight_rst_o, .rd_feature_ld_o, .rd_rom_signals_ld_o,
        .load_cnt_clr_o(load_cnt_clr), .load_cnt_en_o(load_cnt_en),
        .ready_cnt_clr_o(ready_cnt_clr), .ready_cnt_en_o(ready_cnt_en),
        .drain_cnt_clr_o(drain_cnt_clr), .drain_cnt_en_o(drain_cnt_en),
        .feat_clr_o(feat_clr), .feat_en_o(feat_en),
        .round_clr_o(round_clr), .bank_clr_o(bank_clr), .bank_ld_o(bank_ld)
    );

    sa_phase_counters #(.N_COLS(N_COLS)) u_counters (
        .clk_i, .sel_mux_tr_rst, .filter_size_i,
        .load_cnt_clr_i(load_cnt_clr), .load_cnt_en_i(load_cnt_en),
        .ready_cnt_clr_i(ready_cnt_clr), .ready_cnt_en_i(ready_cnt_en),
        .drain_cnt_clr_i(drain_cnt_clr), .drain_cnt_en_i(drain_cnt_en),
        .feat_clr_i(feat_clr), .feat_en_i(feat_en),
        .load_done_o(load_done), .ready_done_o(ready_done), .drain_done_o(drain_done),
        .load_count_o(load_count), .feat_addr_o(in_feature_addr_o)
    );

    sa_weight_round #(.N_COLS(N_COLS)) u_round (
        .clk_i, .sel_mux_tr_rst, .round_clr_i(round_clr),
        .load_done_i(load_done), .load_count_i(load_count), .max_round_weight_i,
        .last_round_o(last_round), .rom_addr_o(addrs_rom_signal_o)
    );

    sa_signal_bank #(.N_ROWS(N_ROWS)) u_bank (
        .clk_i, .sel_mux_tr_rst, .bank_clr_i(bank_clr), .bank_ld_i(bank_ld),
        .rom_word_i(rom_signals_data_i),
        .f_sel_o, .num_cols_o(number_of_columns_o),
        .sel_mux_tr_o, .en_adder_o(en_adder_node_o)
    );

endmodule

/* sa_ctrl_asserts.sv */
`timescale 1ns/1ps

module sa_ctrl_asserts #(
    parameter int N_COLS = sa_array_pkg::N_COLS_DEF
) (
    input logic clk_i,
    input logic sel_mux_tr_rst,
    input logic load_o,
    input logic ready_o,
    input logic rst_o
);
    import sa_ctrl_pkg::*;

    int fail_cnt = 0;

    // idle, load and ready never overlap
    a_phase_excl: assert property (@(posedge clk_i) disable iff (sel_mux_tr_rst)
        $onehot0({load_o, ready_o, rst_o}))
        else begin
            $error("load_o, ready_o and rst_o high together");
            fail_cnt++;
        end

    a_load_len: assert property (@(posedge clk_i) disable iff (sel_mux_tr_rst)
        load_o [*N_COLS] |=> !load_o)
        else begin
            $error("load_o high for more than N_COLS cycles");
            fail_cnt++;
        end

    a_ready_len: assert property (@(posedge clk_i) disable iff (sel_mux_tr_rst)
        $rose(ready_o) |-> ready_o [*READY_LEN] ##1 !ready_o)
        else begin
            $error("ready_o not high for exactly READY_LEN cycles");
            fail_cnt++;
        end

endmodule

/* tb_sa_ctrl.sv */
`timescale 1ns/1ps

module tb_sa_ctrl;
    import sa_array_pkg::*;
    import sa_ctrl_pkg::*;

    localparam int N_ROWS = N_ROWS_DEF;
    localparam int N_COLS = N_COLS_DEF;
    localparam int ROM_W  = N_ROWS * ROW_BITS;
    localparam int RUNS   = 12;
    localparam int LIMIT  = RUNS * 4 * (N_COLS + READY_LEN + 8 + 11) + 200;

    logic                   clk_i;
    logic                   sel_mux_tr_rst;
    logic [ROM_W-1:0]       rom_signals_data_i;
    num_cols_t              filter_size_i;
    logic                   end_feature_i;
    logic [ROUND_W-1:0]     max_round_weight_i;
    logic                   rst_o, load_o, ready_o, start_op_o;
    logic                   rd_weight_ld_o, rd_weight_rst_o, rd_feature_ld_o, rd_rom_signals_ld_o;
    logic [FEAT_ADDR_W-1:0] in_feature_addr_o;
    logic [ROM_ADDR_W-1:0]  addrs_rom_signal_o;
    f_sel_t                 f_sel_o             [N_ROWS];
    num_cols_t              number_of_columns_o [N_ROWS];
    sel_mux_tr_t            sel_mux_tr_o        [N_ROWS];
    logic                   en_adder_node_o     [N_ROWS];

    // cycle model state with m_w0 as the newest loaded word
    phase_t           m_state;
    int               m_cyc, m_load_cnt, m_feat, m_round;
    logic [ROM_W-1:0] m_w0, m_w1;
    int               start_len, runs_done;
    int               cycles = 0;

    sa_ctrl_top UUT (.*);

    bind sa_phase_fsm sa_ctrl_asserts u_asserts (.clk_i, .sel_mux_tr_rst, .load_o, .ready_o, .rst_o);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles > LIMIT) begin
            $display("timeout: controller did not finish %0d runs in %0d cycles", RUNS, LIMIT);
            $display("Simulation failed");
            $fatal(1, "run stopped by timeout");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // signal rom and field helpers
    //////////////////////////////////////////////////////////////////////

    // fixed hash in which every address bit reaches the word
    function automatic logic [ROM_W-1:0] rom_word(input logic [ROM_ADDR_W-1:0] a);
        logic [31:0] h;
        h = 32'(a) * 32'h9e37_79b1;
        h = h ^ (h >> 15) ^ 32'h2c1b_3a55;
        return h[ROM_W-1:0];
    endfunction

    assign rom_signals_data_i = rom_word(addrs_rom_signal_o);

    // groups of two-bit fields from the low end
    // group 3 holds the enables
    function automatic logic [1:0] word_field(input logic [ROM_W-1:0] w, input int grp,
                                              input int r);
        if (grp == 3) return {1'b0, w[3*N_ROWS*2 + r]};
        return w[grp*N_ROWS*2 + r*2 +: 2];
    endfunction

    function automatic logic [ROM_ADDR_W-1:0] model_addr();
        return ROM_ADDR_W'(m_round * N_COLS + m_load_cnt);
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Simulation failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic new_run();
        filter_size_i      = num_cols_t'(1 + $urandom % MAX_FILTER);
        max_round_weight_i = ROUND_W'(1 + $urandom % 4);
        start_len          = 1 + $urandom % 8;
    endtask

    task automatic enter(input phase_t s);
        m_state = s;
        m_cyc   = 0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // model step at each rising edge
    //////////////////////////////////////////////////////////////////////

    task automatic model_step();
        logic [ROM_W-1:0] word;
        int               drain_len;
        logic             is_last;
        word      = rom_word(model_addr());
        is_last   = (m_round == int'(max_round_weight_i));
        drain_len = 2 * (int'(filter_size_i) - 1) + DRAIN_BASE + 1;
        m_cyc++;
        case (m_state)
            idle: begin
                m_load_cnt = 0;
                m_feat     = 0;
                m_round    = 0;
                m_w0       = '0;
                m_w1       = '0;
                if (!is_last) enter(load);
            end
            load: begin
                m_w1 = m_w0;
                m_w0 = word;
                m_load_cnt++;
                m_feat = 0;
                if (m_cyc == N_COLS) begin
                    m_round++;
                    enter(ready);
                end
            end
            ready: begin
                m_load_cnt = 0;
                m_feat++;
                if (m_cyc == READY_LEN) enter(start);
            end
            start: begin
                m_feat++;
                if (end_feature_i) enter(drain);
            end
            default: begin
                m_feat = 0;
                if (m_cyc == drain_len) begin
                    if (is_last) begin
                        runs_done++;
                        enter(idle);
                    end else begin
                        enter(load);
                    end
                end
            end
        endcase
    endtask

    task automatic drive_inputs();
        end_feature_i = (m_state == start) && (m_cyc == start_len - 1);
        // round counter is already clear in the second idle cycle
        if (m_state == idle && m_round == 0) new_run();
    endtask

    task automatic check_outputs();
        check_eq("rst_o", rst_o, m_state == idle);
        check_eq("rd_weight_rst_o", rd_weight_rst_o, m_state == idle);
        check_eq("load_o", load_o, m_state == load);
        check_eq("rd_weight_ld_o", rd_weight_ld_o, m_state == load);
        check_eq("rd_rom_signals_ld_o", rd_rom_signals_ld_o, m_state == load);
        check_eq("ready_o", ready_o, m_state == ready);
        check_eq("rd_feature_ld_o", rd_feature_ld_o, m_state inside {ready, start});
        check_eq("start_op_o", start_op_o, m_state inside {start, drain});
        check_eq("in_feature_addr_o", in_feature_addr_o, m_feat);
        check_eq("addrs_rom_signal_o", addrs_rom_signal_o, model_addr());
        for (int r = 0; r < N_ROWS; r++) begin
            check_eq($sformatf("f_sel_o[%0d]", r), f_sel_o[r], word_field(m_w0, 0, r));
            check_eq($sformatf("number_of_columns_o[%0d]", r), number_of_columns_o[r],
                     word_field(m_w0, 1, r));
            check_eq($sformatf("sel_mux_tr_o[%0d]", r), sel_mux_tr_o[r], word_field(m_w1, 2, r));
            check_eq($sformatf("en_adder_node_o[%0d]", r), en_adder_node_o[r],
                     word_field(m_w0, 3, r));
        end
    endtask

    initial begin
        void'($urandom(92));
        sel_mux_tr_rst     = 1'b1;
        end_feature_i      = 1'b0;
        filter_size_i      = 1;
        max_round_weight_i = 1;
        runs_done          = 0;
        m_load_cnt         = 0;
        m_feat             = 0;
        m_round            = 0;
        m_w0               = '0;
        m_w1               = '0;
        enter(idle);
        new_run();
        repeat (8) begin
            @(negedge clk_i);
            check_outputs();
        end
        @(posedge clk_i);
        #5;
        sel_mux_tr_rst = 1'b0;
        @(negedge clk_i);
        check_outputs();
        while (runs_done < RUNS) begin
            @(posedge clk_i);
            model_step();
            #5;
            drive_inputs();
            @(negedge clk_i);
            check_outputs();
        end
        if (UUT.u_fsm.u_asserts.fail_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* src.f */
sa_array_pkg.sv
sa_ctrl_pkg.sv
sa_rom_field_reg.sv
sa_signal_bank.sv
sa_phase_fsm.sv
sa_phase_counters.sv
sa_weight_round.sv
sa_ctrl_top.sv
sa_ctrl_asserts.sv
tb_sa_ctrl.sv

/* Bender.yml */
package:
  name: sa_ctrl

sources:
  - sa_array_pkg.sv
  - sa_ctrl_pkg.sv
  - sa_rom_field_reg.sv
  - sa_signal_bank.sv
  - sa_phase_fsm.sv
  - sa_phase_counters.sv
  - sa_weight_round.sv
  - sa_ctrl_top.sv
  - target: test
    files:
      - sa_ctrl_asserts.sv
      - tb_sa_ctrl.sv
